//--- src/gb_cart_pkg.sv
// ----------------------------------------------------------------------
// Cartridge header definitions shared by the capture, mapper and backup
// Header word addresses, RAM enable key, controller kind, header struct
// ----------------------------------------------------------------------

package gb_cart_pkg;

	// ------------------------------------------------------------------
	// Download stream and header layout
	// ------------------------------------------------------------------
	localparam int IOCTL_ADDR_W = 25;                   // Byte address of the download stream
	localparam logic [IOCTL_ADDR_W-1:0] HDR_TYPE_ADDR = 'h146; // Type in the upper byte
	localparam logic [IOCTL_ADDR_W-1:0] HDR_SIZE_ADDR = 'h148; // ROM size low, RAM size high

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;       // Low nibble that opens the RAM
	localparam int ROM_BANK_W = 9;                      // Up to 512 banks of 16 KB

	// Controller kinds that the mapper knows
	typedef enum logic [1:0] {
		KIND_NONE = 2'd0,  // 32 KB linear
		KIND_MBC1 = 2'd1,
		KIND_MBC5 = 2'd2
	} mbc_kind_t;

	// Decoded header, valid once the header words went past
	typedef struct packed {
		mbc_kind_t             kind;
		logic                  battery;     // Cartridge keeps RAM across power off
		logic [ROM_BANK_W-1:0] rom_mask;    // Mirrors bank numbers onto the real ROM size
		logic [1:0]            ram_mask;    // RAM bank bits that exist
		logic [5:0]            last_block;  // Last 512-byte block of the save file
		logic                  has_ram;
		logic                  loading;     // Cartridge download in progress
	} cart_header_t;

endpackage

//--- src/gb_mem_pkg.sv
// ----------------------------------------------------------------------
// Cartridge RAM and ROM address widths
// Request and response structs of the shared cartridge RAM
// ----------------------------------------------------------------------

package gb_mem_pkg;

	localparam int CRAM_ADDR_W  = 15;  // 32 KB of cartridge RAM
	localparam int BLOCK_ADDR_W = 9;   // Byte offset within a 512-byte block
	localparam int LBA_W        = 6;   // Up to 64 blocks
	localparam int ROM_ADDR_W   = 23;  // 512 banks of 16 KB

	// Which peer a read belongs to
	typedef enum logic {
		OWNER_CPU    = 1'b0,
		OWNER_BACKUP = 1'b1
	} cram_owner_t;

	typedef struct packed {
		logic                   rd;
		logic                   wr;
		logic [CRAM_ADDR_W-1:0] addr;
		logic [7:0]             data;  // Write byte
	} cram_req_t;

	typedef struct packed {
		logic        valid;  // Read data present this cycle
		logic [7:0]  data;
		cram_owner_t owner;
	} cram_rsp_t;

endpackage

//--- src/cart_header_capture.sv
// ----------------------------------------------------------------------
// Cartridge header capture from the download stream
// Decodes controller kind, battery, ROM and RAM masks, save size
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module cart_header_capture (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 ioctl_download,
	input  logic                                 ioctl_wr,
	input  logic [gb_cart_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]                          ioctl_dout,
	output gb_cart_pkg::cart_header_t            header
);

	logic [7:0] cart_type;  // Header byte 147
	logic [7:0] rom_size;   // Header byte 148
	logic [7:0] ram_size;   // Header byte 149

	// Grab the two header words as they stream past
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= 8'd0;
			rom_size  <= 8'd0;
			ram_size  <= 8'd0;
		end else if (ioctl_download && ioctl_wr) begin
			if (ioctl_addr == gb_cart_pkg::HDR_TYPE_ADDR)
				cart_type <= ioctl_dout[15:8];            // Low byte is the SGB flag
			if (ioctl_addr == gb_cart_pkg::HDR_SIZE_ADDR)
				{ram_size, rom_size} <= ioctl_dout;
		end
	end

	always_comb begin
		header.kind = gb_cart_pkg::KIND_NONE;
		if (cart_type >= 8'h01 && cart_type <= 8'h03)
			header.kind = gb_cart_pkg::KIND_MBC1;
		else if (cart_type >= 8'h19 && cart_type <= 8'h1E)
			header.kind = gb_cart_pkg::KIND_MBC5;

		header.battery = (cart_type == 8'h03) || (cart_type == 8'h1B) || (cart_type == 8'h1E);

		// Size code n means 2 << n banks
		if (rom_size <= 8'd8)
			header.rom_mask = ~({gb_cart_pkg::ROM_BANK_W{1'b1}} << (rom_size[3:0] + 4'd1));
		else
			header.rom_mask = 9'h07F;                     // Odd sizes fold onto 128 banks

		header.ram_mask = (ram_size == 8'd3) ? 2'b11 : 2'b00;  // Only 32 KB has 4 banks

		case (ram_size)
			8'd1:    header.last_block = 6'd3;   // 2 KB
			8'd2:    header.last_block = 6'd15;  // 8 KB
			8'd3:    header.last_block = 6'd63;  // 32 KB
			default: header.last_block = 6'd0;
		endcase

		header.has_ram = |ram_size;
		header.loading = ioctl_download;
	end

endmodule

//--- src/mbc_mapper.sv
// ----------------------------------------------------------------------
// Memory bank controller for no MBC, MBC1 and MBC5
// Bank registers, ROM and RAM address mapping, CPU read data
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mbc_mapper (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  gb_cart_pkg::cart_header_t             header,
	input  logic                                  ce_cpu,
	input  logic [15:0]                           cart_addr,
	input  logic                                  cart_rd,
	input  logic                                  cart_wr,
	input  logic [7:0]                            cart_di,
	output logic [7:0]                            cart_do,
	output logic [gb_mem_pkg::ROM_ADDR_W-1:0]     rom_addr,
	output logic                                  rom_rd,
	input  logic [7:0]                            rom_data,
	output gb_mem_pkg::cram_req_t                 req,
	input  gb_mem_pkg::cram_rsp_t                 rsp,
	output logic                                  cpu_ram_wr
);

	logic                               ram_en;    // RAM gate opened by the key
	logic [gb_cart_pkg::ROM_BANK_W-1:0] rom_bank;
	logic [1:0]                         ram_bank;  // Also upper ROM bits on MBC1
	logic                               mode;      // MBC1 banking mode
	logic                               sel_ram;   // Last CPU read went to cart RAM
	logic [7:0]                         ram_q;     // Held RAM read byte
	logic                               is_mbc1;
	logic                               is_mbc5;
	logic                               rd_stb;
	logic                               wr_stb;
	logic                               is_cram;
	logic                               ram_ok;
	logic                               cpu_rsp;
	logic [gb_cart_pkg::ROM_BANK_W-1:0] bank_hi;   // Bank seen at 4000-7FFF
	logic [gb_cart_pkg::ROM_BANK_W-1:0] bank_lo;   // Bank seen at 0000-3FFF
	logic [1:0]                         ram_bank_eff;

	assign is_mbc1 = header.kind == gb_cart_pkg::KIND_MBC1;
	assign is_mbc5 = header.kind == gb_cart_pkg::KIND_MBC5;
	assign rd_stb  = ce_cpu & cart_rd;
	assign wr_stb  = ce_cpu & cart_wr;
	assign is_cram = cart_addr[15:13] == 3'b101;  // A000-BFFF
	assign ram_ok  = ram_en & header.has_ram;
	assign cpu_rsp = rsp.valid && (rsp.owner == gb_mem_pkg::OWNER_CPU);

	// ------------------------------------------------------------------
	// Register writes, decoded by 8 KB region
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || header.loading) begin
			ram_en   <= 1'b0;
			rom_bank <= 9'd1;
			ram_bank <= 2'd0;
			mode     <= 1'b0;
		end else if (wr_stb) begin
			case (cart_addr[15:13])
				3'b000: ram_en <= cart_di[3:0] == gb_cart_pkg::RAM_ENABLE_KEY;
				3'b001: begin
					if (is_mbc1)                          // Bank 0 reads as 1
						rom_bank <= {4'd0, (cart_di[4:0] == 5'd0) ? 5'd1 : cart_di[4:0]};
					else if (is_mbc5 && cart_addr[12])
						rom_bank[8] <= cart_di[0];          // 3000-3FFF
					else if (is_mbc5)
						rom_bank[7:0] <= cart_di;           // 2000-2FFF, 0 allowed
				end
				3'b010: ram_bank <= cart_di[1:0];
				3'b011: begin
					if (is_mbc1)
						mode <= cart_di[0];
				end
				default: ;
			endcase
		end
	end

	// ROM banking
	always_comb begin
		bank_lo = '0;
		case (header.kind)
			gb_cart_pkg::KIND_MBC1: begin
				bank_hi = {2'b00, ram_bank, rom_bank[4:0]} & header.rom_mask;
				if (mode)                                 // Upper bits reach bank 0 area too
					bank_lo = {2'b00, ram_bank, 5'd0} & header.rom_mask;
			end
			gb_cart_pkg::KIND_MBC5: bank_hi = rom_bank & header.rom_mask;
			default:                bank_hi = 9'd1;      // Plain 32 KB
		endcase
	end

	assign rom_addr = {cart_addr[14] ? bank_hi : bank_lo, cart_addr[13:0]};
	assign rom_rd   = rd_stb & ~cart_addr[15];

	// MBC1 only banks RAM in mode 1
	assign ram_bank_eff = (is_mbc5 || (is_mbc1 && mode)) ? (ram_bank & header.ram_mask) : 2'd0;

	assign req.rd     = rd_stb & is_cram & ram_ok;
	assign req.wr     = wr_stb & is_cram & ram_ok;
	assign req.addr   = {ram_bank_eff, cart_addr[12:0]};
	assign req.data   = cart_di;
	assign cpu_ram_wr = req.wr;

	// ------------------------------------------------------------------
	// Read data path
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset)
			sel_ram <= 1'b0;
		else if (rd_stb)
			sel_ram <= is_cram;
	end

	always_ff @(posedge clk_sys) begin
		if (rd_stb && is_cram && !ram_ok)
			ram_q <= 8'hFF;                             // Closed or absent RAM
		else if (cpu_rsp)
			ram_q <= rsp.data;
	end

	// ROM byte is live, RAM byte comes a cycle later and then holds
	assign cart_do = (rom_rd || !sel_ram) ? rom_data : (cpu_rsp ? rsp.data : ram_q);

endmodule

//--- src/cram_arbiter.sv
// ----------------------------------------------------------------------
// Cartridge RAM arbiter between the CPU mapper and the backup streamer
// CPU always wins, read data is tagged with its owner
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module cram_arbiter (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  gb_mem_pkg::cram_req_t cpu_req,
	input  gb_mem_pkg::cram_req_t bk_req,
	output logic                  bk_gnt,
	output gb_mem_pkg::cram_req_t mem_req,
	input  logic [7:0]            mem_q,
	output gb_mem_pkg::cram_rsp_t rsp
);

	logic                    cpu_act;
	logic                    bk_act;
	logic                    rd_valid;  // A read went into the RAM last cycle
	gb_mem_pkg::cram_owner_t rd_owner;

	assign cpu_act = cpu_req.rd | cpu_req.wr;
	assign bk_act  = bk_req.rd | bk_req.wr;

	// Backup waits one cycle at most, CPU never issues twice in a row
	assign mem_req = cpu_act ? cpu_req : bk_req;
	assign bk_gnt  = bk_act & ~cpu_act;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_valid <= 1'b0;
			rd_owner <= gb_mem_pkg::OWNER_CPU;
		end else begin
			rd_valid <= mem_req.rd;
			rd_owner <= cpu_act ? gb_mem_pkg::OWNER_CPU : gb_mem_pkg::OWNER_BACKUP;
		end
	end

	// Broadcast, each peer filters on owner
	assign rsp.valid = rd_valid;
	assign rsp.data  = mem_q;
	assign rsp.owner = rd_owner;

endmodule

//--- src/cram_store.sv
// ----------------------------------------------------------------------
// Single-port byte-wide RAM, synchronous write and registered read
// Request word packs read, write, address and data, MSB first
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module cram_store #(
	parameter int ADDR_W = 15,
	parameter int DATA_W = 8
) (
	input  logic                       clk_sys,
	input  logic [ADDR_W+DATA_W+1:0]   mem_req,
	output logic [DATA_W-1:0]          mem_q
);

	logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
	logic              rd;
	logic              wr;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;

	assign {rd, wr, addr, data} = mem_req;

	always_ff @(posedge clk_sys) begin
		if (wr)
			mem[addr] <= data;
		if (rd)
			mem_q <= mem[addr];  // Held until the next read
	end

endmodule

//--- src/backup_streamer.sv
// ----------------------------------------------------------------------
// Save and load of the cartridge RAM over the block device
// Block sequencing, buffer access queue, pending save flag
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module backup_streamer (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  gb_cart_pkg::cart_header_t             header,
	input  logic                                  img_mounted,
	input  logic                                  bk_load,
	input  logic                                  bk_save,
	input  logic                                  cpu_ram_wr,
	output logic [gb_mem_pkg::LBA_W-1:0]          sd_lba,
	output logic                                  sd_rd,
	output logic                                  sd_wr,
	input  logic                                  sd_ack,
	input  logic [gb_mem_pkg::BLOCK_ADDR_W-1:0]   sd_buff_addr,
	input  logic                                  sd_buff_wr,
	input  logic                                  sd_buff_rd,
	input  logic [7:0]                            sd_buff_dout,
	output logic [7:0]                            sd_buff_din,
	output logic                                  sd_buff_valid,
	output gb_mem_pkg::cram_req_t                 req,
	input  logic                                  bk_gnt,
	input  gb_mem_pkg::cram_rsp_t                 rsp,
	output logic                                  sav_pending,
	output logic                                  bk_busy
);

	logic supported;  // Battery RAM with a mounted save image
	logic loading;    // Direction of the running transfer
	logic old_ack;
	logic start;

	assign supported = header.battery & header.has_ram & img_mounted;
	assign start     = ~bk_busy & supported & (bk_load | bk_save);

	// ------------------------------------------------------------------
	// Block sequencer
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_busy <= 1'b0;
			loading <= 1'b0;
			sd_lba  <= '0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			old_ack <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			if (~old_ack & sd_ack)
				{sd_rd, sd_wr} <= 2'b00;                // Host took the block request
			if (start) begin
				bk_busy <= 1'b1;
				loading <= bk_load;
				sd_lba  <= '0;
				sd_rd   <= bk_load;
				sd_wr   <= ~bk_load;
			end else if (bk_busy && old_ack && !sd_ack) begin
				if (sd_lba == header.last_block)
					bk_busy <= 1'b0;                     // Whole RAM done
				else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= loading;
					sd_wr  <= ~loading;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// Buffer strobes wait here until the arbiter grants them
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req.rd <= 1'b0;
			req.wr <= 1'b0;
		end else if (sd_ack && (sd_buff_rd || sd_buff_wr)) begin
			req.rd <= sd_buff_rd;
			req.wr <= sd_buff_wr;
		end else if (bk_gnt) begin
			req.rd <= 1'b0;
			req.wr <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sd_ack && (sd_buff_rd || sd_buff_wr)) begin
			req.addr <= {sd_lba, sd_buff_addr};  // Block number picks the 512-byte slice
			req.data <= sd_buff_dout;
		end
	end

	// Read byte goes straight back to the host
	assign sd_buff_valid = rsp.valid && (rsp.owner == gb_mem_pkg::OWNER_BACKUP);
	assign sd_buff_din   = rsp.data;

	always_ff @(posedge clk_sys) begin
		if (reset)
			sav_pending <= 1'b0;
		else if (start)
			sav_pending <= 1'b0;
		else if (cpu_ram_wr && supported)
			sav_pending <= 1'b1;
	end

endmodule

//--- src/gb_cart_top.sv
// ----------------------------------------------------------------------
// Cartridge side top level
// Header capture, mapper, RAM arbiter, cartridge RAM, backup streamer
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module gb_cart_top (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	// Download stream
	input  logic                                  ioctl_download,
	input  logic                                  ioctl_wr,
	input  logic [gb_cart_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  logic [15:0]                           ioctl_dout,
	// CPU bus
	input  logic                                  ce_cpu,
	input  logic [15:0]                           cart_addr,
	input  logic                                  cart_rd,
	input  logic                                  cart_wr,
	input  logic [7:0]                            cart_di,
	output logic [7:0]                            cart_do,
	// External ROM
	output logic [gb_mem_pkg::ROM_ADDR_W-1:0]     rom_addr,
	output logic                                  rom_rd,
	input  logic [7:0]                            rom_data,
	// Block device
	output logic [gb_mem_pkg::LBA_W-1:0]          sd_lba,
	output logic                                  sd_rd,
	output logic                                  sd_wr,
	input  logic                                  sd_ack,
	input  logic [gb_mem_pkg::BLOCK_ADDR_W-1:0]   sd_buff_addr,
	input  logic                                  sd_buff_wr,
	input  logic                                  sd_buff_rd,
	input  logic [7:0]                            sd_buff_dout,
	output logic [7:0]                            sd_buff_din,
	output logic                                  sd_buff_valid,
	// Backup control and status
	input  logic                                  img_mounted,
	input  logic                                  bk_load,
	input  logic                                  bk_save,
	output logic                                  sav_pending,
	output logic                                  bk_busy
);

	gb_cart_pkg::cart_header_t header;
	gb_mem_pkg::cram_req_t     cpu_req;
	gb_mem_pkg::cram_req_t     bk_req;
	gb_mem_pkg::cram_req_t     mem_req;
	gb_mem_pkg::cram_rsp_t     rsp;      // Shared by both peers
	logic [7:0]                mem_q;
	logic                      bk_gnt;
	logic                      cpu_ram_wr;

	cart_header_capture u_header (
		.clk_sys, .reset, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.header
	);

	mbc_mapper u_mapper (
		.clk_sys, .reset, .header, .ce_cpu, .cart_addr, .cart_rd, .cart_wr, .cart_di,
		.cart_do, .rom_addr, .rom_rd, .rom_data,
		.req(cpu_req), .rsp, .cpu_ram_wr
	);

	cram_arbiter u_arbiter (
		.clk_sys, .reset, .cpu_req, .bk_req, .bk_gnt, .mem_req, .mem_q, .rsp
	);

	cram_store #(
		.ADDR_W(gb_mem_pkg::CRAM_ADDR_W),
		.DATA_W(8)
	) u_cram (
		.clk_sys, .mem_req, .mem_q
	);

	backup_streamer u_backup (
		.clk_sys, .reset, .header, .img_mounted, .bk_load, .bk_save, .cpu_ram_wr,
		.sd_lba, .sd_rd, .sd_wr, .sd_ack, .sd_buff_addr, .sd_buff_wr, .sd_buff_rd,
		.sd_buff_dout, .sd_buff_din, .sd_buff_valid,
		.req(bk_req), .bk_gnt, .rsp, .sav_pending, .bk_busy
	);

endmodule

//--- test/tb_gb_cart.sv
// ----------------------------------------------------------------------
// Testbench for the cartridge top level
// Clock, reset, command player, block-device host model, reference RAM
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_gb_cart;

	localparam int BLOCK_WAIT = 400;    // Cycles allowed for a block request or busy drop
	localparam int BYTE_WAIT  = 8;      // Cycles allowed for a save byte
	localparam int LBA_WAIT   = 20000;  // Cycles allowed for the load to leave block 0

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ce_cpu;
	logic [15:0] cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_di;
	logic [7:0]  cart_do;
	logic [22:0] rom_addr;
	logic        rom_rd;
	logic [7:0]  rom_data;
	logic [5:0]  sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        sd_ack;
	logic [8:0]  sd_buff_addr;
	logic        sd_buff_wr;
	logic        sd_buff_rd;
	logic [7:0]  sd_buff_dout;
	logic [7:0]  sd_buff_din;
	logic        sd_buff_valid;
	logic        img_mounted;
	logic        bk_load;
	logic        bk_save;
	logic        sav_pending;
	logic        bk_busy;

	// Reference copy of the cartridge RAM
	logic [7:0] ram_copy [0:32767];
	bit         ram_known [0:32767];  // Byte has a known value

	// Mapper model that tracks only what the RAM address needs
	int         m_kind;   // 0 none, 1 MBC1, 2 MBC5
	logic       m_en;
	logic [1:0] m_bank;
	logic       m_mode;
	logic [1:0] m_ram_mask;
	logic       m_has_ram;
	int         m_last;   // Last save block

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;

	gb_cart_top UUT (.*);

	always #20 clk_sys = ~clk_sys;  // 40 ns period

	// CPU enable on every second cycle
	always @(posedge clk_sys)
		ce_cpu <= reset ? 1'b0 : ~ce_cpu;

	assign rom_data = rom_addr[7:0] ^ rom_addr[21:14];  // Stand-in ROM contents

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	task automatic abort_run(input string why);
		errors++;
		$display("ERROR: %s", why);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic expect_equal(input string sig, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s: got %h, expected %h", sig, got, exp);
			errors++;
		end
	endtask

	// RAM bank masked by ram_mask and used on MBC1 only in mode 1
	function automatic logic [14:0] cram_index(input logic [15:0] a);
		logic [1:0] eb;
		eb = 2'd0;
		if (m_kind == 2 || (m_kind == 1 && m_mode))
			eb = m_bank & m_ram_mask;
		return {eb, a[12:0]};
	endfunction

	function automatic string line_tail(input string s);
		int e;
		e = s.len() - 1;
		while (e > 1 && (s.getc(e) == "\n" || s.getc(e) == "\r" || s.getc(e) == " "))
			e--;
		return s.substr(2, e);
	endfunction

	task automatic download_header(input logic [7:0] ctype, input logic [7:0] rom_code,
			input logic [7:0] ram_code);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		@(posedge clk_sys);
		ioctl_addr <= 25'h146;
		ioctl_dout <= {ctype, 8'h00};      // Type in the upper byte
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		ioctl_addr <= 25'h148;
		ioctl_dout <= {ram_code, rom_code};
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		m_kind = (ctype >= 8'h01 && ctype <= 8'h03) ? 1 :
			(ctype >= 8'h19 && ctype <= 8'h1E) ? 2 : 0;
		m_ram_mask = (ram_code == 8'd3) ? 2'b11 : 2'b00;
		m_has_ram  = ram_code != 8'd0;
		m_last     = (ram_code == 8'd1) ? 3 : (ram_code == 8'd2) ? 15 : (ram_code == 8'd3) ? 63 : 0;
		m_en       = 1'b0;                 // Registers reset while loading
		m_bank     = 2'd0;
		m_mode     = 1'b0;
	endtask

	// One CPU access in a ce_cpu cycle with rom_addr and rom_rd taken in that cycle
	// and cart_do taken in the next
	task automatic cpu_access(input logic wr, input logic [15:0] addr, input logic [7:0] di,
			output logic [22:0] ra, output logic rr, output logic [7:0] q);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (ce_cpu && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (ce_cpu)
			abort_run("ce_cpu never went low");
		@(posedge clk_sys);                // ce_cpu rises here
		cart_addr <= addr;
		cart_rd   <= !wr;
		cart_wr   <= wr;
		cart_di   <= di;
		@(negedge clk_sys);
		ra = rom_addr;
		rr = rom_rd;
		@(posedge clk_sys);
		cart_rd <= 1'b0;
		cart_wr <= 1'b0;
		@(negedge clk_sys);
		q = cart_do;
	endtask

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		case (a[15:13])
			3'b000: m_en = d[3:0] == 4'hA;
			3'b010: m_bank = d[1:0];
			3'b011: if (m_kind == 1) m_mode = d[0];
			3'b101: begin
				if (m_en && m_has_ram) begin
					ram_copy[cram_index(a)]  = d;
					ram_known[cram_index(a)] = 1'b1;
				end
			end
			default: ;
		endcase
	endtask

	// ------------------------------------------------------------------
	// Block-device host for save reads and load writes
	// ------------------------------------------------------------------
	task automatic host_transfer(input logic is_load, input int last);
		int b;
		int i;
		int n;
		logic [7:0]  byte_val;
		logic [14:0] idx;
		for (b = 0; b <= last; b++) begin
			n = 0;
			@(negedge clk_sys);
			while (!(is_load ? sd_rd : sd_wr) && n < BLOCK_WAIT) begin
				@(negedge clk_sys);
				n++;
			end
			if (!(is_load ? sd_rd : sd_wr))
				abort_run($sformatf("no request came for block %0d", b));
			expect_equal("sd_lba", 32'(sd_lba), b);
			@(posedge clk_sys);
			sd_ack <= 1'b1;
			for (i = 0; i < 512; i++) begin
				idx      = {b[5:0], i[8:0]};
				byte_val = 8'h00;
				if (is_load)
					byte_val = 8'($urandom);
				@(posedge clk_sys);
				sd_buff_addr <= i[8:0];
				sd_buff_dout <= byte_val;
				sd_buff_wr   <= is_load;
				sd_buff_rd   <= !is_load;
				if (is_load) begin
					ram_copy[idx]  = byte_val;
					ram_known[idx] = 1'b1;
				end
				@(posedge clk_sys);
				sd_buff_wr <= 1'b0;
				sd_buff_rd <= 1'b0;
				if (!is_load) begin
					n = 0;
					@(negedge clk_sys);
					while (!sd_buff_valid && n < BYTE_WAIT) begin
						@(negedge clk_sys);
						n++;
					end
					if (!sd_buff_valid)
						abort_run($sformatf("no save byte for block %0d offset %0d", b, i));
					if (ram_known[idx])                   // Untouched bytes have no reference
						expect_equal("sd_buff_din", 32'(sd_buff_din), 32'(ram_copy[idx]));
				end
				repeat (3) @(posedge clk_sys);          // Keep strobes 4 or more apart
			end
			@(negedge clk_sys);
			expect_equal("sd_rd|sd_wr", 32'(sd_rd | sd_wr), 0);  // Dropped on the ack edge
			@(posedge clk_sys);
			sd_ack <= 1'b0;
		end
		n = 0;
		@(negedge clk_sys);
		while (bk_busy && n < BLOCK_WAIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy)
			abort_run("bk_busy stayed high after the last block");
	endtask

	// CPU reads of block 0 while later blocks still load
	task automatic load_reader();
		int n;
		int k;
		logic [22:0] ra;
		logic        rr;
		logic [7:0]  q;
		logic [15:0] a;
		n = 0;
		@(negedge clk_sys);
		while (sd_lba == 6'd0 && n < LBA_WAIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (sd_lba == 6'd0)
			abort_run("load never moved past block 0");
		for (k = 0; k < 12; k++) begin
			a = 16'hA000 + 16'(k * 37);
			cpu_access(1'b0, a, 8'h00, ra, rr, q);
			expect_equal("cart_do", 32'(q), 32'(ram_copy[cram_index(a)]));
		end
		expect_equal("bk_busy", 32'(bk_busy), 1);   // Reads really overlapped the load
	endtask

	task automatic run_save();
		@(posedge clk_sys);
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		host_transfer(1'b0, m_last);
		@(negedge clk_sys);
		expect_equal("sav_pending", 32'(sav_pending), 0);
	endtask

	task automatic run_load();
		@(posedge clk_sys);
		bk_load <= 1'b1;
		@(posedge clk_sys);
		bk_load <= 1'b0;
		fork
			host_transfer(1'b1, m_last);
			load_reader();
		join
	endtask

	task automatic end_test(input string tname);
		tests_run++;
		if (errors == test_start_errors)
			$display("test %s: ok", tname);
		else begin
			$display("test %s: %0d errors", tname, errors - test_start_errors);
			tests_failed++;
		end
		test_start_errors = errors;
	endtask

	// ------------------------------------------------------------------
	// Command player
	// ------------------------------------------------------------------
	initial begin
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [22:0] ra;
		logic        rr;
		logic [7:0]  q;
		int          fd;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ce_cpu         = 1'b0;
		cart_addr      = '0;
		cart_rd        = 1'b0;
		cart_wr        = 1'b0;
		cart_di        = '0;
		sd_ack         = 1'b0;
		sd_buff_addr   = '0;
		sd_buff_wr     = 1'b0;
		sd_buff_rd     = 1'b0;
		sd_buff_dout   = '0;
		img_mounted    = 1'b0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		void'($urandom(71));
		repeat (8) @(posedge clk_sys);
		reset       <= 1'b0;
		img_mounted <= 1'b1;               // Save image present for the whole run
		fd = $fopen("test/cart_stimulus.txt", "r");
		if (fd == 0)
			abort_run("cannot open test/cart_stimulus.txt");
		else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() == 0)
					continue;
				op = line.getc(0);
				if (op == "#" || op == "\n" || op == "\r" || op == " ")
					continue;
				a = '0;
				b = '0;
				c = '0;
				void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
				case (op)
					"H": download_header(a[7:0], b[7:0], c[7:0]);
					"W": begin
						cpu_access(1'b1, a[15:0], b[7:0], ra, rr, q);
						model_write(a[15:0], b[7:0]);
					end
					"R": begin
						cpu_access(1'b0, a[15:0], 8'h00, ra, rr, q);
						expect_equal("rom_rd", 32'(rr), {31'd0, ~a[15]});
						expect_equal("cart_do", 32'(q), b);
					end
					"A": begin
						cpu_access(1'b0, a[15:0], 8'h00, ra, rr, q);
						expect_equal("rom_addr", 32'(ra), b);
						expect_equal("rom_rd", 32'(rr), 1);
						expect_equal("cart_do", 32'(q), 32'(b[7:0] ^ b[21:14]));  // ROM byte
					end
					"V": begin
						cpu_access(1'b0, a[15:0], 8'h00, ra, rr, q);
						expect_equal("rom_rd", 32'(rr), {31'd0, ~a[15]});
						expect_equal("cart_do", 32'(q), 32'(ram_copy[cram_index(a[15:0])]));
					end
					"P": begin
						@(negedge clk_sys);
						expect_equal("sav_pending", 32'(sav_pending), a);
					end
					"S": run_save();
					"L": run_load();
					"E": end_test(line_tail(line));
					default: abort_run($sformatf("unknown command %s in stimulus", op));
				endcase
			end
			$fclose(fd);
			$display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
				tests_run, tests_failed, checks, errors);
			if (errors == 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

endmodule

//--- test/cart_stimulus.txt
# H type rom_code ram_code | W addr data | R addr cart_do | A addr rom_addr | P sav_pending
# V addr read checked against reference RAM | S save | L load | E test name, values in hex
H 03 05 03
W 2000 00
A 4123 004123
W 2000 45
A 4000 014000
E mbc1_rom_bank
W 4000 01
W 6000 01
A 0010 080010
A 4000 094000
E mbc1_mode
P 0
R A000 FF
W 0000 0A
W A000 11
W A1FF 22
W 4000 02
W A005 33
R A005 33
W 4000 01
R A000 11
R A1FF 22
P 1
E cart_ram
H 1B 08 03
W 2000 34
W 3000 01
A 4000 4D0000
A 5ABC 4D1ABC
W 0000 0A
W 4000 03
W A010 5A
R A010 5A
W 4000 01
R A000 11
E mbc5
S
P 0
E save
W 4000 00
L
V A000
V BFFF
W 4000 02
V A123
W 4000 03
V A010
V BFFF
E load

//--- files.f
src/gb_cart_pkg.sv
src/gb_mem_pkg.sv
src/cart_header_capture.sv
src/mbc_mapper.sv
src/cram_arbiter.sv
src/cram_store.sv
src/backup_streamer.sv
src/gb_cart_top.sv
test/tb_gb_cart.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gb_cart \
	-f files.f -o tb_gb_cart \
	&& ./obj_dir/tb_gb_cart | tee sim.log
grep -q "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
